/* source/io_pkg.sv */
package io_pkg;

	// bus widths shared by every block on the IO bus
	localparam int DATA_BITS = 16;
	localparam int ADDR_BITS = 16;

	// upper address bits of each 16 word block
	localparam logic [ADDR_BITS-5:0] UART_BASE = 12'h010;
	localparam logic [ADDR_BITS-5:0] GPIO_BASE = 12'h011;
	localparam logic [ADDR_BITS-5:0] PWM_BASE  = 12'h012;

	// request handed from the decoder to each peripheral
	typedef struct packed {
		logic [3:0]           offset; // word within the block
		logic [DATA_BITS-1:0] wdata;
	} io_req_t;

	// which block the current address hits
	typedef enum logic [1:0] {
		DEV_NONE,
		DEV_UART,
		DEV_GPIO,
		DEV_PWM
	} dev_sel_e;

endpackage

/* source/io_decoder.sv */
`timescale 1ns/100ps

module io_decoder #(
	parameter int PWM_CHANNELS = 3
) (
	input  logic [io_pkg::ADDR_BITS-1:0] ADDRESS,
	input  logic [io_pkg::DATA_BITS-1:0] DATA_IN,
	input  logic                         memWR,
	output io_pkg::dev_sel_e             sel,
	output io_pkg::io_req_t              req,
	output logic                         wr_uart,
	output logic                         wr_gpio,
	output logic [PWM_CHANNELS-1:0]      wr_pwm
);

	import io_pkg::*;

	logic [ADDR_BITS-5:0] block;  // 16 word block number
	logic [2:0]           pwm_ch; // channel index inside the PWM block

	assign block  = ADDRESS[ADDR_BITS-1:4];
	assign pwm_ch = ADDRESS[3:1];

	// local request is the same for every device
	assign req.offset = ADDRESS[3:0];
	assign req.wdata  = DATA_IN;

	always_comb begin
		sel = DEV_NONE;
		if (block == UART_BASE) begin
			sel = DEV_UART;
		end else if (block == GPIO_BASE) begin
			sel = DEV_GPIO;
		end else if (block == PWM_BASE) begin
			// channels past the last instance are a hole in the map
			if (int'(pwm_ch) < PWM_CHANNELS)
				sel = DEV_PWM;
		end
	end

	assign wr_uart = memWR && (sel == DEV_UART);
	assign wr_gpio = memWR && (sel == DEV_GPIO);

	// one hot strobe, only the addressed channel sees the write
	always_comb begin
		wr_pwm = '0;
		for (int i = 0; i < PWM_CHANNELS; i++) begin
			if (memWR && (sel == DEV_PWM) && (int'(pwm_ch) == i))
				wr_pwm[i] = 1'b1;
		end
	end

endmodule

/* source/pwm_channel.sv */
`timescale 1ns/100ps

module pwm_channel (
	input  logic                         CLK,
	input  logic                         RSTb,
	input  io_pkg::io_req_t              req,
	input  logic                         wr,
	output logic [io_pkg::DATA_BITS-1:0] rdata,
	output logic                         pwm
);

	import io_pkg::*;

	logic [7:0] duty;
	logic       enable;
	logic [7:0] count; // free running, wraps every 256 cycles

	// offset bit 0 picks duty or enable
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			duty   <= 8'd0;
			enable <= 1'b0;
		end else if (wr) begin
			if (req.offset[0])
				enable <= req.wdata[0];
			else
				duty <= req.wdata[7:0];
		end
	end

	always_ff @(posedge CLK) begin
		if (!RSTb)
			count <= 8'd0;
		else
			count <= count + 8'd1;
	end

	// high for exactly duty cycles out of every 256
	assign pwm = enable && (count < duty);

	always_comb begin
		rdata = '0;
		if (req.offset[0])
			rdata[0] = enable;
		else
			rdata[7:0] = duty;
	end

endmodule

/* source/gpio.sv */
`timescale 1ns/100ps

module gpio (
	input  logic                         CLK,
	input  logic                         RSTb,
	input  io_pkg::io_req_t              req,
	input  logic                         wr,
	output logic [io_pkg::DATA_BITS-1:0] rdata,
	input  logic [5:0]                   in_pins,
	output logic [3:0]                   out_pins,
	output logic                         edge_irq
);

	import io_pkg::*;

	logic [3:0] out_reg;
	logic [5:0] sync_1;  // first stage, may go metastable
	logic [5:0] sync_2;  // safe to use from here on
	logic       in0_dly; // previous value of input 0

	always_ff @(posedge CLK) begin
		if (!RSTb)
			out_reg <= 4'd0;
		else if (wr && (req.offset == 4'd0))
			out_reg <= req.wdata[3:0];
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			sync_1   <= 6'd0;
			sync_2   <= 6'd0;
			in0_dly  <= 1'b0;
			edge_irq <= 1'b0;
		end else begin
			sync_1   <= in_pins;
			sync_2   <= sync_1;
			in0_dly  <= sync_2[0];
			edge_irq <= sync_2[0] && !in0_dly; // single cycle on rise
		end
	end

	assign out_pins = out_reg;

	always_comb begin
		rdata = '0;
		case (req.offset)
			4'd0: rdata[3:0] = out_reg;
			4'd1: rdata[5:0] = sync_2;
			default: ;
		endcase
	end

endmodule

/* source/uart_tx.sv */
`timescale 1ns/100ps

module uart_tx #(
	parameter int CLKS_PER_BIT = 87
) (
	input  logic                         CLK,
	input  logic                         RSTb,
	input  io_pkg::io_req_t              req,
	input  logic                         wr,
	output logic [io_pkg::DATA_BITS-1:0] rdata,
	output logic                         tx,
	output logic                         done_irq
);

	import io_pkg::*;

	localparam int CNT_BITS = $clog2(CLKS_PER_BIT + 1);
	localparam logic [CNT_BITS-1:0] LAST_CLK = CNT_BITS'(CLKS_PER_BIT - 1);

	logic                busy;
	logic [CNT_BITS-1:0] clk_cnt; // cycles into the current bit
	logic [3:0]          bit_cnt; // 0 is start, 9 is stop
	logic [9:0]          shifter; // stop, data, start; bit 0 is on the line
	logic                start;
	logic                bit_end;

	// a write while a frame is out is dropped
	assign start   = wr && (req.offset == 4'd0) && !busy;
	assign bit_end = (clk_cnt == LAST_CLK);

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			busy     <= 1'b0;
			clk_cnt  <= '0;
			bit_cnt  <= 4'd0;
			done_irq <= 1'b0;
		end else begin
			done_irq <= 1'b0;
			if (start) begin
				busy    <= 1'b1;
				clk_cnt <= '0;
				bit_cnt <= 4'd0;
			end else if (busy) begin
				if (bit_end) begin
					clk_cnt <= '0;
					bit_cnt <= bit_cnt + 4'd1;
					if (bit_cnt == 4'd9) begin // end of stop bit
						busy     <= 1'b0;
						done_irq <= 1'b1;
					end
				end else begin
					clk_cnt <= clk_cnt + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (!RSTb)
			shifter <= 10'h3ff;
		else if (start)
			shifter <= {1'b1, req.wdata[7:0], 1'b0};
		else if (busy && bit_end)
			shifter <= {1'b1, shifter[9:1]};
	end

	// line idles high between frames
	assign tx = busy ? shifter[0] : 1'b1;

	always_comb begin
		rdata    = '0;
		rdata[0] = busy;
	end

endmodule

/* source/io_read_mux.sv */
`timescale 1ns/100ps

module io_read_mux #(
	parameter int PWM_CHANNELS = 3
) (
	input  logic                         CLK,
	input  logic                         RSTb,
	input  io_pkg::dev_sel_e             sel,
	input  logic [3:0]                   offset,
	input  logic                         rd,
	input  logic [io_pkg::DATA_BITS-1:0] uart_rdata,
	input  logic [io_pkg::DATA_BITS-1:0] gpio_rdata,
	input  logic [io_pkg::DATA_BITS-1:0] pwm_rdata [PWM_CHANNELS],
	output logic [io_pkg::DATA_BITS-1:0] DATA_OUT
);

	import io_pkg::*;

	logic [DATA_BITS-1:0] pwm_val;
	logic [DATA_BITS-1:0] rd_val;

	// channel index sits in offset[3:1]
	always_comb begin
		pwm_val = '0;
		for (int i = 0; i < PWM_CHANNELS; i++) begin
			if (int'(offset[3:1]) == i)
				pwm_val = pwm_rdata[i];
		end
	end

	always_comb begin
		case (sel)
			DEV_UART: rd_val = uart_rdata;
			DEV_GPIO: rd_val = gpio_rdata;
			DEV_PWM:  rd_val = pwm_val;
			default:  rd_val = '0; // unmapped reads as zero
		endcase
	end

	// value from the read cycle, held until the next read
	always_ff @(posedge CLK) begin
		if (!RSTb)
			DATA_OUT <= '0;
		else if (rd)
			DATA_OUT <= rd_val;
	end

endmodule

/* source/port_controller.sv */
`timescale 1ns/100ps

module port_controller #(
	parameter int CLOCK_FREQ   = 10000000,
	parameter int BAUD_RATE    = 115200,
	parameter int PWM_CHANNELS = 3          // at most 6, PINS[13:8]
) (
	input  logic                         CLK,
	input  logic                         RSTb,
	input  logic [io_pkg::ADDR_BITS-1:0] ADDRESS,
	input  logic [io_pkg::DATA_BITS-1:0] DATA_IN,
	output logic [io_pkg::DATA_BITS-1:0] DATA_OUT,
	input  logic                         memWR,
	input  logic                         memRD,
	output logic [31:0]                  PINS,
	input  logic [7:0]                   INPUT_PINS,
	output logic [1:0]                   irq
);

	import io_pkg::*;

	localparam int CLKS_PER_BIT = CLOCK_FREQ / BAUD_RATE;

	dev_sel_e             sel;
	io_req_t              req;
	logic                 wr_uart;
	logic                 wr_gpio;
	logic [PWM_CHANNELS-1:0] wr_pwm;

	logic [DATA_BITS-1:0] uart_rdata;
	logic [DATA_BITS-1:0] gpio_rdata;
	logic [DATA_BITS-1:0] pwm_rdata [PWM_CHANNELS];

	logic                    uart_tx_pin;
	logic                    uart_done;
	logic [3:0]              gpio_out;
	logic                    gpio_irq;
	logic [PWM_CHANNELS-1:0] pwm_out;

	io_decoder #(.PWM_CHANNELS(PWM_CHANNELS)) u_decoder (
		.ADDRESS (ADDRESS),
		.DATA_IN (DATA_IN),
		.memWR   (memWR),
		.sel     (sel),
		.req     (req),
		.wr_uart (wr_uart),
		.wr_gpio (wr_gpio),
		.wr_pwm  (wr_pwm)
	);

	uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart (
		.CLK      (CLK),
		.RSTb     (RSTb),
		.req      (req),
		.wr       (wr_uart),
		.rdata    (uart_rdata),
		.tx       (uart_tx_pin),
		.done_irq (uart_done)
	);

	gpio u_gpio (
		.CLK      (CLK),
		.RSTb     (RSTb),
		.req      (req),
		.wr       (wr_gpio),
		.rdata    (gpio_rdata),
		.in_pins  (INPUT_PINS[5:0]), // top two inputs not connected
		.out_pins (gpio_out),
		.edge_irq (gpio_irq)
	);

	for (genvar i = 0; i < PWM_CHANNELS; i++) begin : g_pwm
		pwm_channel u_pwm (
			.CLK   (CLK),
			.RSTb  (RSTb),
			.req   (req),
			.wr    (wr_pwm[i]),
			.rdata (pwm_rdata[i]),
			.pwm   (pwm_out[i])
		);
	end

	io_read_mux #(.PWM_CHANNELS(PWM_CHANNELS)) u_read_mux (
		.CLK        (CLK),
		.RSTb       (RSTb),
		.sel        (sel),
		.offset     (req.offset),
		.rd         (memRD),
		.uart_rdata (uart_rdata),
		.gpio_rdata (gpio_rdata),
		.pwm_rdata  (pwm_rdata),
		.DATA_OUT   (DATA_OUT)
	);

	// tx on 15, LEDs from 8 up, GPIO on 3:0, everything else low
	assign PINS = {16'd0, uart_tx_pin, 7'(pwm_out), 4'd0, gpio_out};
	assign irq  = {gpio_irq, uart_done};

endmodule

/* sim/tb_tasks.svh */
task automatic report_mismatch(input string name, input logic [31:0] got,
	input logic [31:0] exp);
	errors++;
	$display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
endtask

// strobe held for one clock and takes effect on the closing edge
task automatic bus_write(input logic [15:0] addr, input logic [15:0] data);
	@(posedge CLK);
	ADDRESS <= addr;
	DATA_IN <= data;
	memWR   <= 1'b1;
	@(posedge CLK);
	memWR <= 1'b0;
endtask

task automatic bus_read(input logic [15:0] addr, output logic [15:0] data);
	@(posedge CLK);
	ADDRESS <= addr;
	memRD   <= 1'b1;
	@(posedge CLK);
	memRD <= 1'b0;
	@(negedge CLK); // DATA_OUT settled after the capture edge
	data = DATA_OUT;
endtask

task automatic reset_test();
	@(negedge CLK);
	if (DATA_OUT !== 16'h0000)
		report_mismatch("DATA_OUT", 32'(DATA_OUT), 32'h0);
	if (irq !== 2'b00)
		report_mismatch("irq", 32'(irq), 32'h0);
	if (PINS !== 32'h0000_8000)
		report_mismatch("PINS", PINS, 32'h0000_8000);
endtask

task automatic gpio_test();
	logic [15:0] rd;
	logic [7:0]  in_val;
	int          pulses;
	gpio_val = 4'($random(seed));
	bus_write(16'h0110, {12'h000, gpio_val});
	@(negedge CLK);
	if (PINS[3:0] !== gpio_val)
		report_mismatch("PINS[3:0]", 32'(PINS[3:0]), 32'(gpio_val));
	bus_read(16'h0110, rd);
	if (rd !== {12'h000, gpio_val})
		report_mismatch("DATA_OUT", 32'(rd), 32'(gpio_val));

	in_val = 8'($random(seed));
	@(posedge CLK);
	INPUT_PINS <= in_val;
	repeat (4) @(posedge CLK); // two sync stages plus margin
	bus_read(16'h0111, rd);
	if (rd !== {10'h000, in_val[5:0]})
		report_mismatch("DATA_OUT", 32'(rd), 32'(in_val[5:0]));

	// park input 0 low long enough for any old pulse to pass
	@(posedge CLK);
	INPUT_PINS <= 8'h00;
	repeat (6) @(posedge CLK);
	INPUT_PINS <= 8'h01;
	pulses = 0;
	repeat (10) begin
		@(negedge CLK);
		if (irq[1])
			pulses++;
	end
	if (pulses != 1) begin
		errors++;
		$display("GPIO edge interrupt pulsed %0d times for one rising edge", pulses);
	end
endtask

task automatic pwm_readback();
	logic [15:0] rd;
	for (int n = 0; n < 3; n++) begin
		bus_read(16'(16'h0120 + 2 * n), rd);
		if (rd !== {8'h00, duty[n]})
			report_mismatch("DATA_OUT", 32'(rd), 32'(duty[n]));
		bus_read(16'(16'h0121 + 2 * n), rd);
		if (rd !== 16'h0001)
			report_mismatch("DATA_OUT", 32'(rd), 32'h1);
	end
endtask

task automatic pwm_test();
	int high_cnt [3];
	for (int n = 0; n < 3; n++) begin
		duty[n] = 8'($random(seed));
		bus_write(16'(16'h0120 + 2 * n), {8'h00, duty[n]});
		bus_write(16'(16'h0121 + 2 * n), 16'h0001);
		high_cnt[n] = 0;
	end
	// any 256 cycle window holds exactly duty high cycles
	repeat (256) begin
		@(negedge CLK);
		for (int n = 0; n < 3; n++) begin
			if (PINS[8 + n])
				high_cnt[n]++;
		end
	end
	for (int n = 0; n < 3; n++) begin
		if (high_cnt[n] != int'(duty[n]))
			report_mismatch("PWM high count", 32'(high_cnt[n]), 32'(duty[n]));
	end
	pwm_readback();
endtask

// called on the write edge so cycle 0 is the start bit
task automatic sample_uart_frame(input logic [7:0] data);
	logic [9:0] frame;
	int         irq_pulses;
	frame      = {1'b1, data, 1'b0};
	irq_pulses = 0;
	for (int c = 0; c < 56; c++) begin
		@(negedge CLK);
		if (irq[0])
			irq_pulses++;
		if ((c == 40) && (irq[0] !== 1'b1))
			report_mismatch("irq[0]", 32'(irq[0]), 32'h1); // done as busy falls
		if (c < 40) begin
			if ((c % 4 == 2) && (PINS[15] !== frame[c / 4]))
				report_mismatch("PINS[15]", 32'(PINS[15]), 32'(frame[c / 4]));
		end else if (PINS[15] !== 1'b1) begin
			report_mismatch("PINS[15]", 32'(PINS[15]), 32'h1); // idle after stop bit
		end
	end
	if (irq_pulses != 1) begin
		errors++;
		$display("UART done interrupt pulsed %0d times for one frame", irq_pulses);
	end
endtask

task automatic uart_test(input logic second_write);
	logic [7:0]  data;
	logic [15:0] rd;
	data = 8'($random(seed));
	bus_write(16'h0100, {8'h00, data});
	fork
		sample_uart_frame(data);
		begin
			repeat (5) @(posedge CLK);
			if (second_write)
				bus_write(16'h0100, {8'h00, ~data}); // must be dropped
			bus_read(16'h0100, rd);
			if (rd !== 16'h0001)
				report_mismatch("DATA_OUT", 32'(rd), 32'h1);
		end
	join
endtask

task automatic unmapped_test();
	logic [15:0] holes [3];
	logic [15:0] junk;
	logic [15:0] rd;
	holes = '{16'h0200, 16'h0130, 16'h0126};
	junk  = 16'($random(seed));
	junk[3:0] = ~gpio_val; // a stray GPIO write would show on the pins
	for (int i = 0; i < 3; i++)
		bus_write(holes[i], junk);
	for (int i = 0; i < 3; i++) begin
		bus_read(16'h0121, rd); // leave a nonzero value on DATA_OUT first
		@(posedge CLK);
		ADDRESS <= holes[i]; // new address without a strobe
		repeat (2) @(posedge CLK);
		@(negedge CLK);
		if (DATA_OUT !== 16'h0001)
			report_mismatch("DATA_OUT", 32'(DATA_OUT), 32'h1);
		bus_read(holes[i], rd);
		if (rd !== 16'h0000)
			report_mismatch("DATA_OUT", 32'(rd), 32'h0);
	end
	@(negedge CLK);
	if (PINS[3:0] !== gpio_val)
		report_mismatch("PINS[3:0]", 32'(PINS[3:0]), 32'(gpio_val));
	if (PINS[15] !== 1'b1)
		report_mismatch("PINS[15]", 32'(PINS[15]), 32'h1);
	if ((PINS & 32'hffff_78f0) !== 32'h0)
		report_mismatch("PINS unused", PINS & 32'hffff_78f0, 32'h0);
	bus_read(16'h0110, rd);
	if (rd !== {12'h000, gpio_val})
		report_mismatch("DATA_OUT", 32'(rd), 32'(gpio_val));
	bus_read(16'h0100, rd); // no frame started
	if (rd !== 16'h0000)
		report_mismatch("DATA_OUT", 32'(rd), 32'h0);
	pwm_readback();
endtask

/* sim/tb_port_controller.sv */
`timescale 1ns/100ps

module tb_port_controller;

	logic        CLK;
	logic        RSTb;
	logic [15:0] ADDRESS;
	logic [15:0] DATA_IN;
	logic [15:0] DATA_OUT;
	logic        memWR;
	logic        memRD;
	logic [31:0] PINS;
	logic [7:0]  INPUT_PINS;
	logic [1:0]  irq;

	integer     seed = 96;
	int         errors = 0;
	logic [3:0] gpio_val;   // last value written to the GPIO output register
	logic [7:0] duty [3];   // duty written to each PWM channel

	// 1 MHz over 250 kBd gives 4 cycles per bit
	port_controller #(
		.CLOCK_FREQ   (1000000),
		.BAUD_RATE    (250000),
		.PWM_CHANNELS (3)
	) u_dut (
		.CLK        (CLK),
		.RSTb       (RSTb),
		.ADDRESS    (ADDRESS),
		.DATA_IN    (DATA_IN),
		.DATA_OUT   (DATA_OUT),
		.memWR      (memWR),
		.memRD      (memRD),
		.PINS       (PINS),
		.INPUT_PINS (INPUT_PINS),
		.irq        (irq)
	);

	`include "tb_tasks.svh"

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	// the whole sequence needs well under a thousand cycles
	initial begin
		repeat (20000) @(posedge CLK);
		$display("watchdog expired after 20000 cycles, test sequence did not finish");
		$display("TB FAILED");
		$finish;
	end

	initial begin
		ADDRESS    <= 16'h0000;
		DATA_IN    <= 16'h0000;
		memWR      <= 1'b0;
		memRD      <= 1'b0;
		INPUT_PINS <= 8'h00;
		RSTb       <= 1'b0;
		repeat (5) @(posedge CLK);
		RSTb <= 1'b1;

		reset_test();
		gpio_test();
		pwm_test();
		uart_test(1'b0);
		uart_test(1'b1); // second write lands mid frame
		unmapped_test();

		$display("checks done, errors: %0d", errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

/* port_controller.f */
+incdir+sim
source/io_pkg.sv
source/io_decoder.sv
source/pwm_channel.sv
source/gpio.sv
source/uart_tx.sv
source/io_read_mux.sv
source/port_controller.sv
sim/tb_port_controller.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f port_controller.f \
	--top-module tb_port_controller -o tb_port_controller

sim_out=$(./obj_dir/tb_port_controller)
echo "$sim_out"

if echo "$sim_out" | grep -qx "TB PASSED"; then
	exit 0
else
	exit 1
fi
